// ==== verilog/throttle_pkg.sv ====
// Shared widths, register map and bus structs for the clock throttle
// Word addressed register map, single transfers only, no byte selects
// Monitor window length must stay a power of two

`default_nettype none

package throttle_pkg;

  // ----------------------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------------------
  // Window counter of the throttle, 8 positions per window
  localparam int cntr_width = 3;
  // Monitor window in clk cycles
  localparam int window_len = 64;
  localparam int window_last = window_len - 1;

  // ----------------------------------------------------------------------
  // Vector types
  // ----------------------------------------------------------------------
  typedef logic [cntr_width-1:0] skip_t;
  typedef logic [2:0] wb_addr_t;
  typedef logic [31:0] wb_data_t;
  // 0 to 64 passed pulses, hence one bit over the window position
  typedef logic [6:0] pulse_cnt_t;
  typedef logic [15:0] window_cnt_t;
  typedef logic [$clog2(window_len)-1:0] window_pos_t;

  // Register word addresses
  localparam wb_addr_t addr_ctrl = 3'd0;
  localparam wb_addr_t addr_skip = 3'd1;
  localparam wb_addr_t addr_status = 3'd2;
  localparam wb_addr_t addr_pulses = 3'd3;
  localparam wb_addr_t addr_windows = 3'd4;

  // ----------------------------------------------------------------------
  // Structs
  // ----------------------------------------------------------------------
  // Wishbone classic request, held by the master until ack
  typedef struct packed {
    logic cyc;
    logic stb;
    logic we;
    wb_addr_t adr;
    wb_data_t dat_w;
  } wb_req_t;

  typedef struct packed {
    wb_data_t dat_r;
    logic ack;
  } wb_rsp_t;

  typedef struct packed {
    logic throttle_en;
    skip_t skip_value;
  } throttle_cfg_t;

  typedef struct packed {
    logic running;
    pulse_cnt_t pulses;
    window_cnt_t windows;
  } throttle_stat_t;

endpackage

`default_nettype wire

// ==== verilog/throttle_wb_regs.sv ====
// Wishbone classic slave for the throttle control and status registers
// One transfer per stb, ack one cycle after the request is seen
// Writes to read-only words are dropped, unmapped words read zero

`timescale 1ns/1ps
`default_nettype none

module throttle_wb_regs (
  input  logic                         clk,
  input  logic                         rst,
  input  throttle_pkg::wb_req_t        wb_req,
  output throttle_pkg::wb_rsp_t        wb_rsp,
  output throttle_pkg::throttle_cfg_t  cfg,
  input  throttle_pkg::throttle_stat_t stat
);

  // Handshake state
  logic ack;
  logic held;
  logic req_active;
  logic req_new;

  // Read path
  throttle_pkg::wb_data_t rd_data;
  throttle_pkg::wb_data_t dat_r;

  // Control and skip registers
  throttle_pkg::throttle_cfg_t cfg_q;

  // ----------------------------------------------------------------------
  // Handshake
  // ----------------------------------------------------------------------
  assign req_active = wb_req.cyc && wb_req.stb;

  // New transfer only when no ack is out and stb has dropped since the last one
  assign req_new = req_active && !ack && !held;

  always_ff @(posedge clk) begin
    if (rst) begin
      ack <= 1'b0;
      held <= 1'b0;
    end else begin
      // Single cycle ack
      ack <= req_new;
      // Block a second ack while the master keeps stb high
      if (!req_active) begin
        held <= 1'b0;
      end else if (ack) begin
        held <= 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Write path
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      cfg_q <= '0;
    end else if (req_new && wb_req.we) begin
      case (wb_req.adr)
        throttle_pkg::addr_ctrl: begin
          cfg_q.throttle_en <= wb_req.dat_w[0];
        end
        throttle_pkg::addr_skip: begin
          cfg_q.skip_value <= wb_req.dat_w[$bits(throttle_pkg::skip_t)-1:0];
        end
        // Status, pulses, windows and holes are not writable
        default: begin
          cfg_q <= cfg_q;
        end
      endcase
    end
  end

  // New settings reach the throttle on the edge that raises ack
  assign cfg = cfg_q;

  // ----------------------------------------------------------------------
  // Read path
  // ----------------------------------------------------------------------
  always_comb begin
    rd_data = '0;
    case (wb_req.adr)
      throttle_pkg::addr_ctrl: begin
        rd_data[0] = cfg_q.throttle_en;
      end
      throttle_pkg::addr_skip: begin
        rd_data[$bits(throttle_pkg::skip_t)-1:0] = cfg_q.skip_value;
      end
      throttle_pkg::addr_status: begin
        // Counter running flag from the throttle
        rd_data[0] = stat.running;
      end
      throttle_pkg::addr_pulses: begin
        rd_data[$bits(throttle_pkg::pulse_cnt_t)-1:0] = stat.pulses;
      end
      throttle_pkg::addr_windows: begin
        rd_data[$bits(throttle_pkg::window_cnt_t)-1:0] = stat.windows;
      end
      default: begin
        rd_data = '0;
      end
    endcase
  end

  // Capture read data with the ack so it is stable for the whole ack cycle
  always_ff @(posedge clk) begin
    if (req_new) begin
      dat_r <= rd_data;
    end
  end

  // Response
  always_comb begin
    wb_rsp.dat_r = dat_r;
    wb_rsp.ack = ack;
  end

endmodule

`default_nettype wire

// ==== verilog/clock_throttle.sv ====
// Pulse swallowing clock throttle with a 3-bit window counter
// Trigger may be asynchronous, set trigger_is_sync when it already comes from clk
// clk_out is gated by a latch, so the clock tree needs a proper gate cell for real use

`timescale 1ns/1ps
`default_nettype none

module clock_throttle #(
  parameter bit trigger_is_sync = 1'b0
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        trigger,
  input  throttle_pkg::throttle_cfg_t cfg,
  output logic                        clk_en,
  output logic                        running,
  output logic                        clk_out
);

  logic sync_trigger;
  logic run;
  logic run_set;
  logic run_clr;
  logic [throttle_pkg::cntr_width-1:0] cntr;
  logic en_latched;

  // ----------------------------------------------------------------------
  // Trigger synchronization
  // ----------------------------------------------------------------------
  if (trigger_is_sync) begin : g_trigger_direct
    // Trigger already in the clk domain
    assign sync_trigger = trigger;
  end else begin : g_trigger_sync
    logic meta;
    logic stable;

    // Two flops, trigger seen two edges after the pin moves
    always_ff @(posedge clk) begin
      if (rst) begin
        meta <= 1'b0;
        stable <= 1'b0;
      end else begin
        meta <= trigger;
        stable <= meta;
      end
    end

    assign sync_trigger = stable;
  end

  // ----------------------------------------------------------------------
  // Run flag and window counter
  // ----------------------------------------------------------------------
  // Start when enabled and triggered
  assign run_set = cfg.throttle_en && sync_trigger;

  // Stop only at the window end, so a window is never cut short
  assign run_clr = (cntr == {throttle_pkg::cntr_width{1'b1}}) &&
                   (!cfg.throttle_en || !sync_trigger);

  always_ff @(posedge clk) begin
    if (rst) begin
      run <= 1'b0;
      cntr <= '0;
    end else begin
      run <= run_set || (run && !run_clr);
      if (!run && run_set) begin
        // Fresh window, first running cycle sees 0
        cntr <= '0;
      end else if (run) begin
        // Wraps from 7 to 0
        cntr <= cntr + 1'b1;
      end
    end
  end

  assign running = run;

  // Pass the pulse when off, idle, or past the skipped positions
  assign clk_en = !cfg.throttle_en || !run || (cntr >= cfg.skip_value);

  // ----------------------------------------------------------------------
  // Clock gate
  // ----------------------------------------------------------------------
  // Latch open in the low phase, so clk_en of cycle k gates the pulse at edge k+1
  // Held closed while rst is high, keeping clk_out low through reset
  always_latch begin
    if (rst) begin
      en_latched <= 1'b0;
    end else if (!clk) begin
      en_latched <= clk_en;
    end
  end

  assign clk_out = clk & en_latched;

endmodule

`default_nettype wire

// ==== verilog/throttle_monitor.sv ====
// Counts enabled clk cycles over fixed windows of window_len cycles
// Result of the last complete window is held until the next window end
// Window count wraps silently after 65535 windows

`timescale 1ns/1ps
`default_nettype none

module throttle_monitor (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      clk_en,
  output throttle_pkg::pulse_cnt_t  pulses,
  output throttle_pkg::window_cnt_t windows
);

  // Position inside the current window
  throttle_pkg::window_pos_t cycle_cnt;
  logic window_end;

  // Enabled cycles seen so far in this window
  throttle_pkg::pulse_cnt_t acc;
  throttle_pkg::pulse_cnt_t acc_next;

  // ----------------------------------------------------------------------
  // Window timing
  // ----------------------------------------------------------------------
  assign window_end = (cycle_cnt == throttle_pkg::window_pos_t'(throttle_pkg::window_last));

  // Power-of-two window, so the counter simply rolls over
  always_ff @(posedge clk) begin
    if (rst) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // Accumulate and latch
  // ----------------------------------------------------------------------
  // Include the current cycle, so the last window cycle is counted too
  assign acc_next = acc + throttle_pkg::pulse_cnt_t'(clk_en);

  always_ff @(posedge clk) begin
    if (rst) begin
      acc <= '0;
      pulses <= '0;
      windows <= '0;
    end else if (window_end) begin
      // Publish this window and start the next from zero
      pulses <= acc_next;
      windows <= windows + 1'b1;
      acc <= '0;
    end else begin
      acc <= acc_next;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/clock_throttle_top.sv ====
// Clock throttle subsystem with Wishbone control and pulse monitor
// Trigger is taken as asynchronous and synchronized inside the throttle
// Single clock domain apart from the trigger pin

`timescale 1ns/1ps
`default_nettype none

module clock_throttle_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  trigger,
  input  throttle_pkg::wb_req_t wb_req,
  output throttle_pkg::wb_rsp_t wb_rsp,
  output logic                  clk_out
);

  // Configuration from the register block
  throttle_pkg::throttle_cfg_t cfg;

  // Status gathered from throttle and monitor
  throttle_pkg::throttle_stat_t stat;

  logic clk_en;

  // Bus slave
  throttle_wb_regs throttle_wb_regs_i (
    .clk    (clk),
    .rst    (rst),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .cfg    (cfg),
    .stat   (stat)
  );

  // Throttle with its own trigger synchronizer
  clock_throttle #(
    .trigger_is_sync (1'b0)
  ) clock_throttle_i (
    .clk     (clk),
    .rst     (rst),
    .trigger (trigger),
    .cfg     (cfg),
    .clk_en  (clk_en),
    .running (stat.running),
    .clk_out (clk_out)
  );

  // Passed pulse monitor
  throttle_monitor throttle_monitor_i (
    .clk     (clk),
    .rst     (rst),
    .clk_en  (clk_en),
    .pulses  (stat.pulses),
    .windows (stat.windows)
  );

endmodule

`default_nettype wire

// ==== testbench/throttle_checker.sv ====
// Reference model of the throttle, the register block and the monitor
// Snoops the bus at the ports, checks clk_out, ack and read data 1 ns after each rising edge

`timescale 1ns/1ps
`default_nettype none

module throttle_checker (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  trigger,
  input  throttle_pkg::wb_req_t wb_req,
  input  throttle_pkg::wb_rsp_t wb_rsp,
  input  logic                  clk_out,
  output int                    errors
);

  // Modeled configuration and throttle state
  logic en_q;
  logic [2:0] skip_q;
  logic sync1;
  logic sync2;
  logic run;
  logic run_n;
  logic [2:0] cntr;
  logic en_now;
  logic exp_out;

  // Modeled bus handshake
  logic ack;
  logic held;
  logic req_new;
  logic rd_we;
  throttle_pkg::wb_data_t rd_exp;

  // Modeled monitor
  int pos;
  throttle_pkg::pulse_cnt_t acc;
  throttle_pkg::pulse_cnt_t pulses;
  throttle_pkg::window_cnt_t windows;

  // Register map as seen from the bus
  function automatic throttle_pkg::wb_data_t read_word(input throttle_pkg::wb_addr_t adr);
    throttle_pkg::wb_data_t d;
    d = '0;
    case (adr)
      3'd0: d[0] = en_q;
      3'd1: d[2:0] = skip_q;
      3'd2: d[0] = run;
      3'd3: d[6:0] = pulses;
      3'd4: d[15:0] = windows;
      default: d = '0;
    endcase
    return d;
  endfunction

  initial begin
    errors = 0;
  end

  always @(posedge clk) begin
    // Enable of the cycle that just ended gates the pulse starting now
    en_now = !en_q || !run || (cntr >= skip_q);
    exp_out = rst ? 1'b0 : en_now;
    if (rst) begin
      en_q = 1'b0;
      skip_q = '0;
      sync1 = 1'b0;
      sync2 = 1'b0;
      run = 1'b0;
      cntr = '0;
      ack = 1'b0;
      held = 1'b0;
      rd_we = 1'b1;
      rd_exp = '0;
      pos = 0;
      acc = '0;
      pulses = '0;
      windows = '0;
    end else begin
      req_new = wb_req.cyc && wb_req.stb && !ack && !held;
      if (req_new) begin
        rd_exp = read_word(wb_req.adr);
        rd_we = wb_req.we;
      end
      if (!(wb_req.cyc && wb_req.stb)) begin
        held = 1'b0;
      end else if (ack) begin
        held = 1'b1;
      end
      ack = req_new;

      // Run flag and window counter
      run_n = (en_q && sync2) || (run && !((cntr == 3'd7) && (!en_q || !sync2)));
      if (!run && en_q && sync2) begin
        cntr = '0;
      end else if (run) begin
        cntr = cntr + 3'd1;
      end
      run = run_n;

      if (req_new && wb_req.we) begin
        if (wb_req.adr == 3'd0) begin
          en_q = wb_req.dat_w[0];
        end else if (wb_req.adr == 3'd1) begin
          skip_q = wb_req.dat_w[2:0];
        end
      end
      sync2 = sync1;
      sync1 = trigger;

      // Monitor window
      if (pos == throttle_pkg::window_len - 1) begin
        pulses = acc + throttle_pkg::pulse_cnt_t'(en_now);
        windows = windows + 16'd1;
        acc = '0;
        pos = 0;
      end else begin
        acc = acc + throttle_pkg::pulse_cnt_t'(en_now);
        pos = pos + 1;
      end
    end

    #1;
    if (clk_out !== exp_out) begin
      $display("FAILED %0t: clk_out %b, expected %b", $time, clk_out, exp_out);
      errors = errors + 1;
    end
    if (wb_rsp.ack !== ack) begin
      $display("FAILED %0t: ack %b, expected %b", $time, wb_rsp.ack, ack);
      errors = errors + 1;
    end
    if (ack && !rd_we && (wb_rsp.dat_r !== rd_exp)) begin
      $display("FAILED %0t: read data %h, expected %h", $time, wb_rsp.dat_r, rd_exp);
      errors = errors + 1;
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_throttle.sv ====
// Testbench for the clock throttle subsystem
// Random bus and trigger stimulus from a fixed seed, model checks in throttle_checker

`timescale 1ns/1ps
`default_nettype none

module tb_clock_throttle;

  logic clk;
  logic rst;
  logic trigger;
  throttle_pkg::wb_req_t wb_req;
  throttle_pkg::wb_rsp_t wb_rsp;
  logic clk_out;

  int seed;
  int errors;
  int chk_errors;
  int test_count;
  int err_mark;
  int pulse_cnt;
  throttle_pkg::wb_data_t rdata;

  clock_throttle_top clock_throttle_top_i (
    .clk     (clk),
    .rst     (rst),
    .trigger (trigger),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp),
    .clk_out (clk_out)
  );

  throttle_checker throttle_checker_i (
    .clk     (clk),
    .rst     (rst),
    .trigger (trigger),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp),
    .clk_out (clk_out),
    .errors  (chk_errors)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Pulses seen on the gated clock
  always @(posedge clk_out) begin
    pulse_cnt = pulse_cnt + 1;
  end

  // ----------------------------------------------------------------------
  // Bus and stimulus tasks
  // ----------------------------------------------------------------------
  task automatic bus_transfer(input logic we, input logic [2:0] adr, input logic [31:0] d);
    int n;
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: d};
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n = n + 1;
      if (n > 20) begin
        $display("Timeout: no Wishbone ack within 20 cycles");
        $display("Simulation failed");
        $finish;
      end
    end while (!wb_rsp.ack);
    rdata = wb_rsp.dat_r;
    wb_req = '0;
    @(posedge clk);
    #1;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Trigger toggles in bursts of 1 to 16 cycles
  task automatic trigger_bursts(input int bursts);
    int len;
    repeat (bursts) begin
      len = ($random(seed) & 15) + 1;
      trigger = ~trigger;
      idle_cycles(len);
    end
  endtask

  task automatic expect_value(input string what, input int got, input int exp);
    if (got != exp) begin
      $display("FAILED %0t: %s is %0d, expected %0d", $time, what, got, exp);
      errors = errors + 1;
    end
  endtask

  // Pulses passed over the given number of clk cycles
  task automatic count_pulses(input int cycles, input int exp);
    pulse_cnt = 0;
    idle_cycles(cycles);
    expect_value("pulse count", pulse_cnt, exp);
  endtask

  task automatic end_test(input string name);
    int now;
    now = errors + chk_errors;
    test_count = test_count + 1;
    $display("test %s: %0d errors", name, now - err_mark);
    err_mark = now;
  endtask

  initial begin
    int n;
    throttle_pkg::wb_addr_t adr;
    seed = 32'ha5522a11;
    errors = 0;
    test_count = 0;
    err_mark = 0;
    pulse_cnt = 0;
    rst = 1'b1;
    trigger = 1'b0;
    wb_req = '0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    // Reset values
    bus_transfer(1'b0, 3'd2, '0);
    expect_value("status", rdata, 0);
    bus_transfer(1'b0, 3'd3, '0);
    expect_value("pulses", rdata, 0);
    bus_transfer(1'b0, 3'd4, '0);
    expect_value("windows", rdata, 0);
    count_pulses(16, 16);
    end_test("reset");

    // Random register access, checker compares every read
    repeat (30) begin
      adr = 3'($random(seed));
      bus_transfer(1'b1, adr, $random(seed));
      // Read back the word just written
      bus_transfer(1'b0, adr, '0);
    end
    for (int a = 0; a < 8; a++) begin
      bus_transfer(1'b0, 3'(a), '0);
    end
    end_test("register access");

    bus_transfer(1'b1, 3'd0, 32'd0);
    trigger_bursts(20);
    end_test("throttling disabled");

    // Random skip values with random trigger activity
    bus_transfer(1'b1, 3'd0, 32'd1);
    repeat (10) begin
      bus_transfer(1'b1, 3'd1, $random(seed));
      trigger_bursts(6);
    end
    trigger = 1'b1;
    bus_transfer(1'b1, 3'd1, 32'd0);
    idle_cycles(4);
    count_pulses(64, 64);
    bus_transfer(1'b1, 3'd1, 32'd7);
    idle_cycles(2);
    count_pulses(64, 8);
    end_test("throttling enabled");

    // Reads after window ends, compared against the modeled counts
    repeat (4) begin
      bus_transfer(1'b1, 3'd1, $random(seed));
      idle_cycles(70);
      bus_transfer(1'b0, 3'd3, '0);
      bus_transfer(1'b0, 3'd4, '0);
    end
    end_test("monitor");

    // Trigger drop, running holds until the counter wraps
    bus_transfer(1'b1, 3'd1, 32'd4);
    idle_cycles(3);
    trigger = 1'b0;
    n = 0;
    do begin
      bus_transfer(1'b0, 3'd2, '0);
      n = n + 1;
      if (n > 20) begin
        $display("Timeout: run flag did not clear after the trigger dropped");
        $display("Simulation failed");
        $finish;
      end
    end while (rdata[0]);
    count_pulses(16, 16);
    end_test("run-flag release");

    $display("%0d tests, %0d errors", test_count, errors + chk_errors);
    if (errors + chk_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== clock_throttle_top.f ====
verilog/throttle_pkg.sv
verilog/throttle_wb_regs.sv
verilog/clock_throttle.sv
verilog/throttle_monitor.sv
verilog/clock_throttle_top.sv
testbench/throttle_checker.sv
testbench/tb_clock_throttle.sv

// ==== Makefile ====
# Verilator build and run of the clock throttle testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_clock_throttle
FILELIST  := clock_throttle_top.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf $(OBJ_DIR)
